/* hw/isaPkg.sv */
// integer subset only; no branch, jump, coprocessor or multiply/divide encodings are defined
package isaPkg;

    typedef logic [31:0] instrT;
    typedef logic [4:0]  regIdxT;
    typedef logic [5:0]  opcodeT;
    typedef logic [5:0]  functT;

    // major opcodes
    localparam opcodeT OP_SPECIAL = 6'd0;   // R-type, operation in funct
    localparam opcodeT OP_ADDIU   = 6'd9;
    localparam opcodeT OP_ORI     = 6'd13;
    localparam opcodeT OP_LUI     = 6'd15;
    localparam opcodeT OP_LW      = 6'd35;
    localparam opcodeT OP_SW      = 6'd43;

    // R-type function codes
    localparam functT FN_ADDU = 6'd33;
    localparam functT FN_SUBU = 6'd35;
    localparam functT FN_AND  = 6'd36;
    localparam functT FN_OR   = 6'd37;
    localparam functT FN_SLT  = 6'd42;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT,    // signed compare
        ALU_LUI     // passes operand B through
    } aluOpT;

endpackage

/* hw/pipePkg.sv */
// pipeline data types; dmemAddrT is 16 bits wide, so the data memory holds at most 64K words
package pipePkg;

    typedef logic [31:0] wordT;

    // where a decode operand is taken from
    typedef enum logic [1:0] {
        FWD_RF,     // register file, no hazard
        FWD_EX,     // ALU output of execute
        FWD_MEM,    // load data or ALU result in memory stage
        FWD_WB      // writeback register, not yet in the register file
    } fwdSelT;

    // word address, sliced down to the memory index width
    typedef logic [15:0] dmemAddrT;

endpackage

/* hw/regFile.sv */
// reads are combinational with no write-through; a same-cycle write is seen only after the edge
`timescale 1ns/10ps

module regFile (
    input  logic           clk,
    input  logic           rstN,
    input  logic           we,
    input  isaPkg::regIdxT wAddr,
    input  pipePkg::wordT  wData,
    input  isaPkg::regIdxT rAddrA,
    input  isaPkg::regIdxT rAddrB,
    output pipePkg::wordT  rDataA,
    output pipePkg::wordT  rDataB
);
    import pipePkg::*;

    wordT regs [32];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && wAddr != '0) begin  // r0 is never written
            regs[wAddr] <= wData;
        end
    end

    assign rDataA = (rAddrA == '0) ? '0 : regs[rAddrA];
    assign rDataB = (rAddrB == '0) ? '0 : regs[rAddrB];

    wAddrKnown: assert property (@(posedge clk) disable iff (!rstN) we |-> !$isunknown(wAddr))
        else $error("register file write with unknown address");

endmodule

/* hw/bypassControl.sv */
// purely combinational; assumes producers with a zero destination already have their write flag low
`timescale 1ns/10ps

module bypassControl (
    input  isaPkg::regIdxT  rs,
    input  isaPkg::regIdxT  rt,
    input  logic            readRs,
    input  logic            readRt,
    input  logic            idValid,
    input  isaPkg::regIdxT  exDst,
    input  isaPkg::regIdxT  memDst,
    input  isaPkg::regIdxT  wbDst,
    input  logic            exRegWrite,
    input  logic            memRegWrite,
    input  logic            wbRegWrite,
    input  logic            exIsLoad,
    output pipePkg::fwdSelT fwdA,
    output pipePkg::fwdSelT fwdB,
    output logic            loadUseStall
);
    import isaPkg::*;
    import pipePkg::*;

    // youngest in-flight producer wins
    function automatic fwdSelT pickSource(regIdxT src, logic used);
        fwdSelT sel;
        sel = FWD_RF;
        if (used && src != '0) begin
            if (exRegWrite && exDst == src) begin
                sel = FWD_EX;
            end else if (memRegWrite && memDst == src) begin
                sel = FWD_MEM;
            end else if (wbRegWrite && wbDst == src) begin
                sel = FWD_WB;
            end
        end
        return sel;
    endfunction

    always_comb begin
        fwdA = pickSource(rs, readRs);
        fwdB = pickSource(rt, readRt);
    end

    // load data is not ready until memory stage
    assign loadUseStall = idValid && exIsLoad && (fwdA == FWD_EX || fwdB == FWD_EX);

endmodule

/* hw/decodeStage.sv */
// the source must hold instr and instrValid while stall is high; unknown opcodes decode as no-ops
`timescale 1ns/10ps

module decodeStage (
    input  logic           clk,
    input  logic           rstN,
    input  logic           instrValid,
    input  isaPkg::instrT  instr,
    input  pipePkg::wordT  exResult,
    input  pipePkg::wordT  memResult,
    input  pipePkg::wordT  wbData,
    input  isaPkg::regIdxT exDst,
    input  isaPkg::regIdxT memDst,
    input  isaPkg::regIdxT wbDst,
    input  logic           exRegWrite,
    input  logic           exIsLoad,
    input  logic           memRegWrite,
    input  logic           wbRegWrite,
    output logic           stall,
    output logic           idValid,
    output isaPkg::aluOpT  idAluOp,
    output pipePkg::wordT  idOpA,
    output pipePkg::wordT  idOpB,
    output pipePkg::wordT  idImm,
    output logic           idUseImm,
    output logic           idRegWrite,
    output logic           idIsLoad,
    output logic           idIsStore,
    output isaPkg::regIdxT idDst
);
    import isaPkg::*;
    import pipePkg::*;

    logic        irValid;
    instrT       ir;
    opcodeT      opcode;
    functT       funct;
    regIdxT      rs;
    regIdxT      rt;
    regIdxT      rd;
    logic [15:0] imm16;
    logic        readRs;
    logic        readRt;
    logic        regWrite;
    wordT        rfA;
    wordT        rfB;
    fwdSelT      fwdA;
    fwdSelT      fwdB;

    // instruction register, held while stalled
    always_ff @(posedge clk) begin
        if (!rstN) begin
            irValid <= 1'b0;
            ir      <= '0;
        end else if (!stall) begin
            irValid <= instrValid;
            if (instrValid) begin
                ir <= instr;
            end
        end
    end

    assign opcode = ir[31:26];
    assign rs     = ir[25:21];
    assign rt     = ir[20:16];
    assign rd     = ir[15:11];
    assign imm16  = ir[15:0];
    assign funct  = ir[5:0];

    always_comb begin
        idAluOp   = ALU_ADD;
        idUseImm  = 1'b0;
        idIsLoad  = 1'b0;
        idIsStore = 1'b0;
        readRs    = 1'b0;
        readRt    = 1'b0;
        regWrite  = 1'b0;
        idDst     = rt;
        idImm     = {{16{imm16[15]}}, imm16};  // sign-extend by default
        case (opcode)
            OP_SPECIAL: begin
                idDst    = rd;
                readRs   = 1'b1;
                readRt   = 1'b1;
                regWrite = 1'b1;
                case (funct)
                    FN_ADDU: idAluOp = ALU_ADD;
                    FN_SUBU: idAluOp = ALU_SUB;
                    FN_AND:  idAluOp = ALU_AND;
                    FN_OR:   idAluOp = ALU_OR;
                    FN_SLT:  idAluOp = ALU_SLT;
                    default: begin  // unknown funct is a no-op
                        readRs   = 1'b0;
                        readRt   = 1'b0;
                        regWrite = 1'b0;
                    end
                endcase
            end
            OP_ADDIU: begin
                readRs   = 1'b1;
                idUseImm = 1'b1;
                regWrite = 1'b1;
            end
            OP_ORI: begin
                idAluOp  = ALU_OR;
                idImm    = {16'b0, imm16};
                readRs   = 1'b1;
                idUseImm = 1'b1;
                regWrite = 1'b1;
            end
            OP_LUI: begin
                idAluOp  = ALU_LUI;
                idImm    = {imm16, 16'b0};
                idUseImm = 1'b1;
                regWrite = 1'b1;
            end
            OP_LW: begin
                readRs   = 1'b1;
                idUseImm = 1'b1;
                idIsLoad = 1'b1;
                regWrite = 1'b1;
            end
            OP_SW: begin
                readRs    = 1'b1;
                readRt    = 1'b1;  // store data
                idUseImm  = 1'b1;
                idIsStore = 1'b1;
            end
            default: ;
        endcase
    end

    assign idRegWrite = regWrite && idDst != '0;
    assign idValid    = irValid && !stall;  // bubble while stalled

    regFile regFile_i (
        .clk    (clk),
        .rstN   (rstN),
        .we     (wbRegWrite),
        .wAddr  (wbDst),
        .wData  (wbData),
        .rAddrA (rs),
        .rAddrB (rt),
        .rDataA (rfA),
        .rDataB (rfB)
    );

    bypassControl bypassControl_i (
        .rs           (rs),
        .rt           (rt),
        .readRs       (readRs),
        .readRt       (readRt),
        .idValid      (irValid),
        .exDst        (exDst),
        .memDst       (memDst),
        .wbDst        (wbDst),
        .exRegWrite   (exRegWrite),
        .memRegWrite  (memRegWrite),
        .wbRegWrite   (wbRegWrite),
        .exIsLoad     (exIsLoad),
        .fwdA         (fwdA),
        .fwdB         (fwdB),
        .loadUseStall (stall)
    );

    function automatic wordT bypassMux(fwdSelT sel, wordT rfData);
        case (sel)
            FWD_EX:  return exResult;
            FWD_MEM: return memResult;
            FWD_WB:  return wbData;
            default: return rfData;
        endcase
    endfunction

    always_comb begin
        idOpA = bypassMux(fwdA, rfA);
        idOpB = bypassMux(fwdB, rfB);
    end

    // the bubble clears execute, so a load-use stall never repeats
    stallOneCycle: assert property (@(posedge clk) disable iff (!rstN) stall |=> !stall)
        else $error("load-use stall held for more than one cycle");

endmodule

/* hw/executeStage.sv */
// single-cycle ALU; no overflow traps, so ADDU and ADDIU wrap silently
`timescale 1ns/10ps

module executeStage (
    input  logic           clk,
    input  logic           rstN,
    input  logic           idValid,
    input  isaPkg::aluOpT  idAluOp,
    input  pipePkg::wordT  idOpA,
    input  pipePkg::wordT  idOpB,
    input  pipePkg::wordT  idImm,
    input  logic           idUseImm,
    input  isaPkg::regIdxT idDst,
    input  logic           idRegWrite,
    input  logic           idIsLoad,
    input  logic           idIsStore,
    output pipePkg::wordT  exResult,
    output isaPkg::regIdxT exDst,
    output logic           exRegWrite,
    output logic           exIsLoad,
    output logic           exIsStore,
    output pipePkg::wordT  exStoreData
);
    import isaPkg::*;
    import pipePkg::*;

    logic   valid;
    aluOpT  aluOp;
    wordT   opA;
    wordT   opB;
    wordT   imm;
    logic   useImm;
    logic   regWrite;
    logic   isLoad;
    logic   isStore;
    wordT   aluB;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            valid    <= 1'b0;
            aluOp    <= ALU_ADD;
            opA      <= '0;
            opB      <= '0;
            imm      <= '0;
            useImm   <= 1'b0;
            exDst    <= '0;
            regWrite <= 1'b0;
            isLoad   <= 1'b0;
            isStore  <= 1'b0;
        end else begin
            valid    <= idValid;
            aluOp    <= idAluOp;
            opA      <= idOpA;
            opB      <= idOpB;
            imm      <= idImm;
            useImm   <= idUseImm;
            exDst    <= idDst;
            regWrite <= idRegWrite;
            isLoad   <= idIsLoad;
            isStore  <= idIsStore;
        end
    end

    assign aluB = useImm ? imm : opB;

    always_comb begin
        case (aluOp)
            ALU_ADD: exResult = opA + aluB;  // also load/store address
            ALU_SUB: exResult = opA - aluB;
            ALU_AND: exResult = opA & aluB;
            ALU_OR:  exResult = opA | aluB;
            ALU_SLT: exResult = {31'b0, $signed(opA) < $signed(aluB)};
            ALU_LUI: exResult = aluB;
            default: exResult = '0;
        endcase
    end

    // bubbles carry no side effects
    assign exRegWrite  = valid && regWrite;
    assign exIsLoad    = valid && isLoad;
    assign exIsStore   = valid && isStore;
    assign exStoreData = opB;

endmodule

/* hw/resultStage.sv */
// word access only; DMEM_WORDS must be a power of two from 16 to 1024, addresses wrap at that depth
`timescale 1ns/10ps

module resultStage #(
    parameter int unsigned DMEM_WORDS = 64
) (
    input  logic           clk,
    input  logic           rstN,
    input  pipePkg::wordT  exResult,
    input  isaPkg::regIdxT exDst,
    input  logic           exRegWrite,
    input  logic           exIsLoad,
    input  logic           exIsStore,
    input  pipePkg::wordT  exStoreData,
    output pipePkg::wordT  memResult,
    output isaPkg::regIdxT memDst,
    output logic           memRegWrite,
    output logic           wbValid,
    output isaPkg::regIdxT wbDst,
    output pipePkg::wordT  wbData,
    output logic           wbRegWrite
);
    import pipePkg::*;

    localparam int unsigned IDX_W = $clog2(DMEM_WORDS);

    wordT             memAlu;
    wordT             memStoreData;
    logic             memIsLoad;
    logic             memIsStore;
    wordT             dmem [DMEM_WORDS];
    dmemAddrT         wordAddr;
    logic [IDX_W-1:0] memIdx;
    logic             wbFlag;

    // memory-stage register
    always_ff @(posedge clk) begin
        if (!rstN) begin
            memAlu       <= '0;
            memStoreData <= '0;
            memDst       <= '0;
            memRegWrite  <= 1'b0;
            memIsLoad    <= 1'b0;
            memIsStore   <= 1'b0;
        end else begin
            memAlu       <= exResult;
            memStoreData <= exStoreData;
            memDst       <= exDst;
            memRegWrite  <= exRegWrite;
            memIsLoad    <= exIsLoad;
            memIsStore   <= exIsStore;
        end
    end

    assign wordAddr = memAlu[17:2];        // byte address to word
    assign memIdx   = wordAddr[IDX_W-1:0];  // wraps at DMEM_WORDS

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < DMEM_WORDS; i++) begin
                dmem[i] <= '0;
            end
        end else if (memIsStore) begin
            dmem[memIdx] <= memStoreData;
        end
    end

    assign memResult = memIsLoad ? dmem[memIdx] : memAlu;

    // writeback register
    always_ff @(posedge clk) begin
        if (!rstN) begin
            wbFlag <= 1'b0;
            wbDst  <= '0;
            wbData <= '0;
        end else begin
            wbFlag <= memRegWrite;
            wbDst  <= memDst;
            wbData <= memResult;
        end
    end

    assign wbValid    = wbFlag;
    assign wbRegWrite = wbFlag;

    loadXorStore: assert property (@(posedge clk) disable iff (!rstN) !(exIsLoad && exIsStore))
        else $error("execute presented a load and a store together");

endmodule

/* hw/coreTop.sv */
// accepts one instruction per clk when instrValid is high and stall low; writeback cannot stall
`timescale 1ns/10ps

module coreTop #(
    parameter int unsigned DMEM_WORDS = 64
) (
    input  logic           clk,
    input  logic           rstN,
    input  logic           instrValid,
    input  isaPkg::instrT  instr,
    output logic           stall,
    output logic           wbValid,
    output isaPkg::regIdxT wbDst,
    output pipePkg::wordT  wbData
);
    import isaPkg::*;
    import pipePkg::*;

    logic   idValid;
    aluOpT  idAluOp;
    wordT   idOpA;
    wordT   idOpB;
    wordT   idImm;
    logic   idUseImm;
    regIdxT idDst;
    logic   idRegWrite;
    logic   idIsLoad;
    logic   idIsStore;
    wordT   exResult;
    regIdxT exDst;
    logic   exRegWrite;
    logic   exIsLoad;
    logic   exIsStore;
    wordT   exStoreData;
    wordT   memResult;
    regIdxT memDst;
    logic   memRegWrite;
    logic   wbRegWrite;

    decodeStage decodeStage_i (
        .clk         (clk),
        .rstN        (rstN),
        .instrValid  (instrValid),
        .instr       (instr),
        .exResult    (exResult),
        .memResult   (memResult),
        .wbData      (wbData),
        .exDst       (exDst),
        .memDst      (memDst),
        .wbDst       (wbDst),
        .exRegWrite  (exRegWrite),
        .exIsLoad    (exIsLoad),
        .memRegWrite (memRegWrite),
        .wbRegWrite  (wbRegWrite),
        .stall       (stall),
        .idValid     (idValid),
        .idAluOp     (idAluOp),
        .idOpA       (idOpA),
        .idOpB       (idOpB),
        .idImm       (idImm),
        .idUseImm    (idUseImm),
        .idRegWrite  (idRegWrite),
        .idIsLoad    (idIsLoad),
        .idIsStore   (idIsStore),
        .idDst       (idDst)
    );

    executeStage executeStage_i (
        .clk         (clk),
        .rstN        (rstN),
        .idValid     (idValid),
        .idAluOp     (idAluOp),
        .idOpA       (idOpA),
        .idOpB       (idOpB),
        .idImm       (idImm),
        .idUseImm    (idUseImm),
        .idDst       (idDst),
        .idRegWrite  (idRegWrite),
        .idIsLoad    (idIsLoad),
        .idIsStore   (idIsStore),
        .exResult    (exResult),
        .exDst       (exDst),
        .exRegWrite  (exRegWrite),
        .exIsLoad    (exIsLoad),
        .exIsStore   (exIsStore),
        .exStoreData (exStoreData)
    );

    resultStage #(
        .DMEM_WORDS (DMEM_WORDS)
    ) resultStage_i (
        .clk         (clk),
        .rstN        (rstN),
        .exResult    (exResult),
        .exDst       (exDst),
        .exRegWrite  (exRegWrite),
        .exIsLoad    (exIsLoad),
        .exIsStore   (exIsStore),
        .exStoreData (exStoreData),
        .memResult   (memResult),
        .memDst      (memDst),
        .memRegWrite (memRegWrite),
        .wbValid     (wbValid),
        .wbDst       (wbDst),
        .wbData      (wbData),
        .wbRegWrite  (wbRegWrite)
    );

endmodule

/* testbench/coreVectors.svh */
// expected values assume registers and data memory are zero after reset and DMEM_WORDS is 64
`ifndef CORE_VECTORS_SVH
`define CORE_VECTORS_SVH

typedef struct packed {
    logic [2:0]  grp;       // test group
    logic        tight;     // issued right after the previous word, no idle gap
    logic [31:0] instr;
    logic        wbExp;     // writeback expected
    logic [4:0]  dst;
    logic [31:0] data;
    logic        stallExp;  // cycles this word waits at the input
} vecT;

localparam int VEC_COUNT = 37;

// columns: group, tight, instruction, writeback expected, destination, data, stall cycles
// a load-use stall shows up on the word after the consumer, since the consumer holds decode
localparam vecT VECS [VEC_COUNT] = '{
    '{3'd0, 1'b0, 32'h34011234, 1'b1, 5'd1,  32'h00001234, 1'b0},  // ori r1, r0, 0x1234
    '{3'd0, 1'b0, 32'h34028000, 1'b1, 5'd2,  32'h00008000, 1'b0},  // ori zero-extends
    '{3'd0, 1'b0, 32'h3C03ABCD, 1'b1, 5'd3,  32'hABCD0000, 1'b0},  // lui r3
    '{3'd0, 1'b0, 32'h2404FFFB, 1'b1, 5'd4,  32'hFFFFFFFB, 1'b0},  // addiu r4, r0, -5
    '{3'd0, 1'b0, 32'h2425FFFF, 1'b1, 5'd5,  32'h00001233, 1'b0},  // addiu r5, r1, -1
    '{3'd0, 1'b0, 32'h34635678, 1'b1, 5'd3,  32'hABCD5678, 1'b0},  // ori r3, r3, 0x5678
    '{3'd1, 1'b0, 32'h00233021, 1'b1, 5'd6,  32'hABCD68AC, 1'b0},  // addu r6, r1, r3
    '{3'd1, 1'b0, 32'h00233823, 1'b1, 5'd7,  32'h5432BBBC, 1'b0},  // subu r7, r1, r3
    '{3'd1, 1'b0, 32'h00614024, 1'b1, 5'd8,  32'h00001230, 1'b0},  // and r8, r3, r1
    '{3'd1, 1'b0, 32'h00414825, 1'b1, 5'd9,  32'h00009234, 1'b0},  // or r9, r2, r1
    '{3'd1, 1'b0, 32'h0081502A, 1'b1, 5'd10, 32'h00000001, 1'b0},  // slt -5 < 0x1234
    '{3'd1, 1'b0, 32'h0024582A, 1'b1, 5'd11, 32'h00000000, 1'b0},  // slt 0x1234 < -5
    '{3'd1, 1'b0, 32'h0061602A, 1'b1, 5'd12, 32'h00000001, 1'b0},  // slt negative r3
    '{3'd2, 1'b0, 32'h340D0010, 1'b1, 5'd13, 32'h00000010, 1'b0},
    '{3'd2, 1'b1, 32'h01AD7021, 1'b1, 5'd14, 32'h00000020, 1'b0},  // distance 1
    '{3'd2, 1'b1, 32'h01AE7821, 1'b1, 5'd15, 32'h00000030, 1'b0},  // distance 2 and 1
    '{3'd2, 1'b1, 32'h01A08021, 1'b1, 5'd16, 32'h00000010, 1'b0},  // distance 3
    '{3'd2, 1'b1, 32'h340D0100, 1'b1, 5'd13, 32'h00000100, 1'b0},
    '{3'd2, 1'b1, 32'h35AD0001, 1'b1, 5'd13, 32'h00000101, 1'b0},
    '{3'd2, 1'b1, 32'h01AE8821, 1'b1, 5'd17, 32'h00000121, 1'b0},  // youngest r13 in EX
    '{3'd2, 1'b1, 32'h01B09023, 1'b1, 5'd18, 32'h000000F1, 1'b0},  // youngest r13 in MEM
    '{3'd3, 1'b0, 32'h34130040, 1'b1, 5'd19, 32'h00000040, 1'b0},  // base 0x40
    '{3'd3, 1'b0, 32'h3C14CAFE, 1'b1, 5'd20, 32'hCAFE0000, 1'b0},
    '{3'd3, 1'b0, 32'h3694BEEF, 1'b1, 5'd20, 32'hCAFEBEEF, 1'b0},
    '{3'd3, 1'b0, 32'hAE740008, 1'b0, 5'd0,  32'h00000000, 1'b0},  // sw r20, 8(r19)
    '{3'd3, 1'b0, 32'hAE73000C, 1'b0, 5'd0,  32'h00000000, 1'b0},  // sw r19, 12(r19)
    '{3'd3, 1'b0, 32'h8E750008, 1'b1, 5'd21, 32'hCAFEBEEF, 1'b0},
    '{3'd3, 1'b0, 32'h8C160148, 1'b1, 5'd22, 32'hCAFEBEEF, 1'b0},  // wraps to word 18
    '{3'd3, 1'b0, 32'h8E77000C, 1'b1, 5'd23, 32'h00000040, 1'b0},
    '{3'd4, 1'b0, 32'h8E780008, 1'b1, 5'd24, 32'hCAFEBEEF, 1'b0},  // lw r24
    '{3'd4, 1'b1, 32'h0313C821, 1'b1, 5'd25, 32'hCAFEBF2F, 1'b0},  // uses r24 at once
    '{3'd4, 1'b1, 32'h8E7A000C, 1'b1, 5'd26, 32'h00000040, 1'b1},
    '{3'd4, 1'b1, 32'h367B0003, 1'b1, 5'd27, 32'h00000043, 1'b0},  // independent of the load
    '{3'd4, 1'b1, 32'h035BE023, 1'b1, 5'd28, 32'hFFFFFFFD, 1'b0},  // load data from MEM
    '{3'd5, 1'b0, 32'h342000FF, 1'b0, 5'd0,  32'h00000000, 1'b0},  // ori r0
    '{3'd5, 1'b1, 32'h00230021, 1'b0, 5'd0,  32'h00000000, 1'b0},  // addu r0
    '{3'd5, 1'b1, 32'h0005E821, 1'b1, 5'd29, 32'h00001233, 1'b0}   // r0 still reads zero
};

`endif

/* testbench/coreTb.sv */
// runs with DMEM_WORDS of 64, which the wrapped load in the vector table relies on
`timescale 1ns/10ps

module coreTb;
    localparam int unsigned DMEM_WORDS = 64;
    localparam int GROUPS = 6;

    logic        clk;
    logic        rstN;
    logic        instrValid;
    logic [31:0] instr;
    logic        stall;
    logic        wbValid;
    logic [4:0]  wbDst;
    logic [31:0] wbData;

    int          passCount;
    int          errorCount;
    logic [36:0] expQ [$];  // {dst, data} in issue order
    logic [36:0] expWb;
    string       groupName [GROUPS] = '{"immediates", "alu ops", "bypass", "memory",
                                        "load-use", "register 0"};

    `include "coreVectors.svh"

    localparam int unsigned TIMEOUT_NS = (VEC_COUNT * 6 + 20) * 20;

    coreTop #(
        .DMEM_WORDS (DMEM_WORDS)
    ) coreTop_i (
        .clk        (clk),
        .rstN       (rstN),
        .instrValid (instrValid),
        .instr      (instr),
        .stall      (stall),
        .wbValid    (wbValid),
        .wbDst      (wbDst),
        .wbData     (wbData)
    );

    always #10 clk = ~clk;

    task automatic checkValue(input string what, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp) begin
            errorCount++;
            $display("** Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end else begin
            passCount++;
        end
    endtask

    // writebacks sampled mid-cycle
    always @(negedge clk) begin
        if (rstN && wbValid) begin
            if (expQ.size() == 0) begin
                errorCount++;
                $display("unexpected writeback to r%0d at %0t ns", wbDst, $time);
            end else begin
                expWb = expQ.pop_front();
                checkValue("writeback destination", {27'b0, wbDst}, {27'b0, expWb[36:32]});
                checkValue("writeback data", wbData, expWb[31:0]);
            end
        end
    end

    initial begin
        #(TIMEOUT_NS);
        $display("timeout: writebacks stopped arriving, %0d still pending", expQ.size());
        $display(">>> FAIL");
        $finish;
    end

    initial begin
        vecT v;
        int  gap;
        int  stallCycles;
        int  grpStart;
        clk        = 1'b0;
        rstN       = 1'b0;
        instrValid = 1'b0;
        instr      = '0;
        passCount  = 0;
        errorCount = 0;
        void'($urandom(32'h9d544d81));
        repeat (3) @(posedge clk);
        rstN <= 1'b1;
        @(negedge clk);
        checkValue("wbValid after reset", {31'b0, wbValid}, 32'd0);
        checkValue("stall after reset", {31'b0, stall}, 32'd0);
        grpStart = errorCount;
        for (int i = 0; i < VEC_COUNT; i++) begin
            v   = VECS[i];
            gap = v.tight ? 0 : $urandom_range(2, 0);
            @(posedge clk);  // previous word accepted here
            if (gap > 0) begin
                instrValid <= 1'b0;
                repeat (gap) @(posedge clk);
            end
            instrValid <= 1'b1;
            instr      <= v.instr;
            if (v.wbExp) begin
                expQ.push_back({v.dst, v.data});
            end
            stallCycles = 0;
            @(negedge clk);
            while (stall) begin  // word held until stall drops
                stallCycles++;
                @(negedge clk);
            end
            checkValue("stall cycles", stallCycles, {31'b0, v.stallExp});
            if (i == VEC_COUNT - 1 || VECS[i + 1].grp != v.grp) begin
                @(posedge clk);
                instrValid <= 1'b0;
                while (expQ.size() != 0) begin
                    @(negedge clk);
                end
                repeat (6) @(negedge clk);  // room for a stray writeback
                $display("group %0d (%s) done, %0d errors", v.grp, groupName[v.grp],
                         errorCount - grpStart);
                grpStart = errorCount;
            end
        end
        $display("checks passed: %0d, errors: %0d", passCount, errorCount);
        if (errorCount == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

/* files.f */
+incdir+testbench
hw/isaPkg.sv
hw/pipePkg.sv
hw/regFile.sv
hw/bypassControl.sv
hw/decodeStage.sv
hw/executeStage.sv
hw/resultStage.sv
hw/coreTop.sv
testbench/coreTb.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module coreTb -f files.f -o coreSim
	./obj_dir/coreSim > sim.log 2>&1
	cat sim.log
	! grep -q ">>> FAIL" sim.log

clean:
	rm -rf obj_dir sim.log
